// ==== design/pov_pkg.sv ====
// shared geometry, colour and timing constants plus the angle and pixel types, imported by all POV blocks
`default_nettype none

package pov_pkg;

    localparam int ROTATIONAL_RES = 1024;             // angular slices in one revolution
    localparam int SCAN_RATE      = 32;               // column steps per half frame
    localparam int NUM_COLS       = 64;               // image width in pixels
    localparam int NUM_ROWS       = 64;               // LEDs on each column
    localparam int RGB_RES        = 9;                // bits per pixel word
    localparam int NUM_ARMS       = 2;                // LED arms on the rotor
    localparam int RADIUS         = 20;               // circle radius in pixels
    localparam int PERIOD_W       = 24;               // revolution period counter width

    // dividing the period by a power of two is just a shift
    localparam int SLICE_SHIFT      = $clog2(ROTATIONAL_RES);
    localparam int SLICE_CNT_W      = PERIOD_W - SLICE_SHIFT; // width of one slice length
    localparam int ARM_SPACING      = ROTATIONAL_RES / NUM_ARMS; // slices between arms
    localparam int CENTER_X         = NUM_COLS / 2;
    localparam int CENTER_Y         = NUM_ROWS / 2;
    localparam int PIXELS_PER_SLICE = NUM_ARMS * 2 * NUM_ROWS; // words shifted per slice
    localparam int PIX_CNT_W        = $clog2(PIXELS_PER_SLICE);

    typedef logic [SLICE_SHIFT-1:0]      theta_t;     // discretized rotor angle
    typedef logic [$clog2(SCAN_RATE)-1:0] col_idx1_t; // left column, 0 to SCAN_RATE-1
    typedef logic [$clog2(SCAN_RATE):0]   col_idx2_t; // right column, SCAN_RATE and up
    typedef logic [RGB_RES-1:0]          pixel_t;

    // index 0 holds the left column and index 1 the right one
    // row 0 of the left column ends up in the lowest bits
    typedef pixel_t [1:0][NUM_ROWS-1:0] column_pair_t;

    localparam pixel_t PIXEL_ON  = '1; // full white for a lit point
    localparam pixel_t PIXEL_OFF = '0;

endpackage

`default_nettype wire

// ==== design/theta_tracker.sv ====
// measures the hall revolution period and slices it into angular steps, feeding the scan sequencer
`timescale 1ns/1ps
`default_nettype none

module theta_tracker (
    input  logic            clk_in,
    input  logic            reset,
    input  logic            hall,          // once per revolution, asynchronous to clk_in
    output logic            slice_strobe,  // one cycle per angular slice
    output pov_pkg::theta_t dtheta,        // slice number since the last hall edge
    output logic            locked         // high once a full period has been measured
);
    import pov_pkg::*;

    logic                   hall_meta;
    logic                   hall_sync;
    logic                   hall_prev;
    logic                   hall_rise;
    logic                   first_seen;   // at least one hall edge has arrived
    logic [PERIOD_W-1:0]    period_cnt;   // cycles since the last edge
    logic [PERIOD_W-1:0]    period_reg;   // last full revolution in cycles
    logic [SLICE_CNT_W-1:0] slice_len;
    logic [SLICE_CNT_W-1:0] slice_cnt;
    logic                   slice_done;
    logic                   theta_last;

    // two flops for metastability, a third one to find the rising edge
    always_ff @(posedge clk_in) begin
        if (reset) begin
            hall_meta <= 1'b0;
            hall_sync <= 1'b0;
            hall_prev <= 1'b0;
        end else begin
            hall_meta <= hall;
            hall_sync <= hall_meta;
            hall_prev <= hall_sync;
        end
    end

    assign hall_rise  = hall_sync && !hall_prev;
    assign slice_len  = period_reg[PERIOD_W-1:SLICE_SHIFT]; // period / ROTATIONAL_RES
    assign slice_done = (slice_cnt + 1'b1) >= slice_len;    // a zero length strobes every cycle
    assign theta_last = (dtheta == theta_t'(ROTATIONAL_RES - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            first_seen   <= 1'b0;
            locked       <= 1'b0;
            period_cnt   <= '0;
            period_reg   <= '0;
            slice_cnt    <= '0;
            slice_strobe <= 1'b0;
            dtheta       <= '0;
        end else begin
            slice_strobe <= 1'b0;
            if (period_cnt != '1) period_cnt <= period_cnt + 1'b1; // saturate when the rotor stalls
            if (hall_rise) begin
                first_seen   <= 1'b1;
                period_cnt   <= PERIOD_W'(1);   // the edge cycle itself counts as one
                period_reg   <= period_cnt;
                slice_cnt    <= '0;
                dtheta       <= '0;
                locked       <= locked || first_seen;
                slice_strobe <= first_seen;     // slice 0 starts right at the edge
            end else if (locked && !theta_last) begin
                // a slow revolution parks on the last slice until the next edge
                if (slice_done) begin
                    slice_cnt    <= '0;
                    slice_strobe <= 1'b1;
                    dtheta       <= dtheta + 1'b1;
                end else begin
                    slice_cnt <= slice_cnt + 1'b1;
                end
            end
        end
    end

    // dtheta can only return to slice 0 through a hall edge, never by wrapping past the top
    a_theta_no_wrap: assert property (@(posedge clk_in) disable iff (reset)
        (slice_strobe && dtheta == '0) |-> $past(hall_rise));

    // no slices go out before the period is known
    a_strobe_locked: assert property (@(posedge clk_in) disable iff (reset)
        !locked |-> !slice_strobe);

endmodule

`default_nettype wire

// ==== design/scan_sequencer.sv ====
// turns each slice strobe into the column pair and per arm angles, then strobes the frame load
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer (
    input  logic                                     clk_in,
    input  logic                                     reset,
    input  logic                                     slice_strobe,
    input  pov_pkg::theta_t                          dtheta,
    input  logic                                     locked,
    output pov_pkg::col_idx1_t                       column_index1, // shared left column
    output pov_pkg::col_idx2_t                       column_index2, // shared right column
    output pov_pkg::theta_t [pov_pkg::NUM_ARMS-1:0] arm_theta,     // angle of every arm
    output logic                                     load           // columns are valid now
);
    import pov_pkg::*;

    logic step_tick;

    assign step_tick = slice_strobe && locked;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            column_index1 <= '0;
            arm_theta     <= '0;
            load          <= 1'b0;
        end else begin
            load <= step_tick; // frame blocks settle in the same cycle the registers update
            if (step_tick) begin
                if (dtheta == '0 || column_index1 == col_idx1_t'(SCAN_RATE - 1)) begin
                    column_index1 <= '0; // restart at the hall edge, wrap on the last step
                end else begin
                    column_index1 <= column_index1 + 1'b1;
                end
                for (int k = 0; k < NUM_ARMS; k++) begin
                    // arms sit evenly around the rotor, the sum wraps modulo ROTATIONAL_RES
                    arm_theta[k] <= dtheta + theta_t'(k * ARM_SPACING);
                end
            end
        end
    end

    // the right column sits SCAN_RATE columns to the right of the left one
    assign column_index2 = col_idx2_t'(SCAN_RATE) + col_idx2_t'(column_index1);

    // every load carries the step of its own slice, which keeps the step below SCAN_RATE
    a_step_range: assert property (@(posedge clk_in) disable iff (reset)
        load |-> int'(column_index1) == int'($past(dtheta)) % SCAN_RATE);

endmodule

`default_nettype wire

// ==== design/hemi_sphere_frame.sv ====
// draws the two pixel columns of one arm for a circle image, lit half by half depending on angle
`timescale 1ns/1ps
`default_nettype none

module hemi_sphere_frame (
    input  pov_pkg::theta_t       dtheta,         // angle this arm sits at
    input  pov_pkg::col_idx1_t    column_index1,  // left column, always left of centre
    input  pov_pkg::col_idx2_t    column_index2,  // right column, at or right of centre
    output pov_pkg::column_pair_t columns
);
    import pov_pkg::*;

    // true when the point lies on or inside the circle
    function automatic logic in_circle(input int dx, input int dy);
        return (dx * dx + dy * dy) <= (RADIUS * RADIUS);
    endfunction

    logic first_half;
    int   dx1;
    int   dx2;

    // in the first half turn the left half glows, after that the right half
    assign first_half = dtheta < theta_t'(ROTATIONAL_RES / 2);

    // column_index1 never reaches CENTER_X so this stays positive
    assign dx1 = CENTER_X - int'(column_index1);
    assign dx2 = int'(column_index2) - CENTER_X;  // column_index2 starts at CENTER_X

    always_comb begin
        int dy;
        for (int y = 0; y < NUM_ROWS; y++) begin
            // distance from the horizontal centre line, rows above and below alike
            if (y < CENTER_Y) begin
                dy = CENTER_Y - y;
            end else begin
                dy = y - CENTER_Y;
            end

            columns[0][y] = PIXEL_OFF; // outside the circle stays dark
            columns[1][y] = PIXEL_OFF;

            if (in_circle(dx1, dy)) begin
                columns[0][y] = first_half ? PIXEL_ON : PIXEL_OFF;
            end
            if (in_circle(dx2, dy)) begin
                columns[1][y] = first_half ? PIXEL_OFF : PIXEL_ON; // opposite polarity
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/column_serializer.sv ====
// captures all arm columns on load and streams them to the LED chain one pixel per cycle
`timescale 1ns/1ps
`default_nettype none

module column_serializer (
    input  logic                                          clk_in,
    input  logic                                          reset,
    input  logic                                          load,
    input  pov_pkg::column_pair_t [pov_pkg::NUM_ARMS-1:0] columns,
    output pov_pkg::pixel_t                               led_data,
    output logic                                          led_valid,  // high for the whole shift
    output logic                                          led_latch   // one cycle after the shift
);
    import pov_pkg::*;

    // every pixel in shift order with arm 0 left row 0 at element 0 and arm N-1 right on top
    pixel_t [PIXELS_PER_SLICE-1:0] shadow;
    logic   [PIX_CNT_W-1:0]        pix_cnt;    // pixels already sent
    logic                          last_pixel;

    assign last_pixel = (pix_cnt == PIX_CNT_W'(PIXELS_PER_SLICE - 1));

    // the shadow buffer shifts down so the next pixel is always at element 0
    always_ff @(posedge clk_in) begin
        if (load) begin
            shadow <= columns;
        end else if (led_valid) begin
            shadow <= {PIXEL_OFF, shadow[PIXELS_PER_SLICE-1:1]};
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            led_valid <= 1'b0;
            led_latch <= 1'b0;
            pix_cnt   <= '0;
        end else begin
            led_latch <= 1'b0;
            if (load) begin
                // a new load wins over a shift still running
                led_valid <= 1'b1;
                pix_cnt   <= '0;
            end else if (led_valid) begin
                if (last_pixel) begin
                    led_valid <= 1'b0;
                    led_latch <= 1'b1; // chain shows the new columns now
                end
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    assign led_data = shadow[0];

    // the slice must be long enough for the full shift and latch
    a_no_overlap: assert property (@(posedge clk_in) disable iff (reset)
        load |-> !led_valid);

endmodule

`default_nettype wire

// ==== design/pov_display_top.sv ====
// top level of the POV frame path from hall input to LED chain, one frame block per arm
`timescale 1ns/1ps
`default_nettype none

module pov_display_top (
    input  logic            clk_in,
    input  logic            reset,
    input  logic            hall,       // raw hall sensor pulse
    output logic            locked,
    output pov_pkg::pixel_t led_data,
    output logic            led_valid,
    output logic            led_latch
);
    import pov_pkg::*;

    logic                                   slice_strobe;
    theta_t                                 dtheta;
    col_idx1_t                              column_index1;
    col_idx2_t                              column_index2;
    theta_t [NUM_ARMS-1:0]                  arm_theta;
    logic                                   load;
    column_pair_t [NUM_ARMS-1:0]            columns;   // one column pair per arm

    theta_tracker u_theta_tracker (
        .clk_in       (clk_in),
        .reset        (reset),
        .hall         (hall),
        .slice_strobe (slice_strobe),
        .dtheta       (dtheta),
        .locked       (locked)
    );

    scan_sequencer u_scan_sequencer (
        .clk_in        (clk_in),
        .reset         (reset),
        .slice_strobe  (slice_strobe),
        .dtheta        (dtheta),
        .locked        (locked),
        .column_index1 (column_index1),
        .column_index2 (column_index2),
        .arm_theta     (arm_theta),
        .load          (load)
    );

    // every arm draws the same column pair at its own angle
    for (genvar k = 0; k < NUM_ARMS; k++) begin : g_arm
        hemi_sphere_frame u_frame (
            .dtheta        (arm_theta[k]),
            .column_index1 (column_index1),
            .column_index2 (column_index2),
            .columns       (columns[k])
        );
    end

    column_serializer u_column_serializer (
        .clk_in    (clk_in),
        .reset     (reset),
        .load      (load),
        .columns   (columns),
        .led_data  (led_data),
        .led_valid (led_valid),
        .led_latch (led_latch)
    );

endmodule

`default_nettype wire

// ==== sim/tb_pov_display.sv ====
// testbench for the POV frame path, drives hall pulses and checks the LED stream against a pixel model
`timescale 1ns/1ps
`default_nettype none

module tb_pov_display;
    import pov_pkg::*;

    localparam int FAST_REV     = ROTATIONAL_RES * 300; // revolution length in cycles at start
    localparam int SLOW_REV     = ROTATIONAL_RES * 400; // revolution length after the change
    localparam int NUM_FAST     = 3;                    // fast revolutions before the change
    localparam int NUM_SLOW     = 2;
    localparam int LOCK_TIMEOUT = 16;
    localparam int TAIL_LATCHES = 8;                    // latches awaited after the last pulse
    localparam int TAIL_TIMEOUT = TAIL_LATCHES * 500;

    logic   clk_in = 1'b0;
    logic   reset;
    logic   hall;
    logic   locked;
    pixel_t led_data;
    logic   led_valid;
    logic   led_latch;

    int          cyc           = 0;   // cycles since reset release
    int          hall_count    = 0;   // hall pulses seen so far
    int          last_hall_cyc = 0;
    int          last_spacing  = 0;   // cycles between the two latest hall pulses
    int          slice_idx     = 0;   // latches since the latest hall pulse, so the slice in flight
    int          pix_idx       = 0;   // valid cycles in the current shift
    int          latch_gap     = 0;   // cycles since the previous latch
    logic        gap_ok        = 1'b0; // previous latch lies in the same revolution
    pixel_t      exp_pix;
    int          pixel_errs    = 0;
    int          framing_errs  = 0;
    int          timing_errs   = 0;
    int          timeout_errs  = 0;
    logic [31:0] rng_state     = 32'd39;

    always #10 clk_in = ~clk_in;

    pov_display_top UUT (
        .clk_in    (clk_in),
        .reset     (reset),
        .hall      (hall),
        .locked    (locked),
        .led_data  (led_data),
        .led_valid (led_valid),
        .led_latch (led_latch)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected word for pixel pix of the shift that belongs to a given slice
    function automatic pixel_t circle_pixel(input int slice, input int pix);
        int   arm;
        int   side;
        int   row;
        int   col;
        int   theta;
        int   dx;
        int   dy;
        logic lit;
        logic left_on;
        arm     = pix / (2 * NUM_ROWS);
        side    = (pix / NUM_ROWS) % 2;                  // 0 is the left column
        row     = pix % NUM_ROWS;
        col     = (side == 0) ? (slice % SCAN_RATE) : (SCAN_RATE + slice % SCAN_RATE);
        theta   = (slice + arm * (ROTATIONAL_RES / NUM_ARMS)) % ROTATIONAL_RES;
        dx      = col - NUM_COLS / 2;
        dy      = row - NUM_ROWS / 2;
        lit     = (dx * dx + dy * dy) <= (RADIUS * RADIUS);
        left_on = theta < ROTATIONAL_RES / 2;            // first half turn lights the left side
        if (!lit) return '0;
        return ((side == 0) == left_on) ? '1 : '0;
    endfunction

    assign exp_pix = circle_pixel(slice_idx, pix_idx);

    // reference model, follows the stream position from hall pulses and latches
    always @(posedge clk_in) begin
        if (reset) begin
            cyc        <= 0;
            hall_count <= 0;
            slice_idx  <= 0;
            pix_idx    <= 0;
            gap_ok     <= 1'b0;
        end else begin
            cyc       <= cyc + 1;
            latch_gap <= latch_gap + 1;
            if (led_valid) pix_idx <= pix_idx + 1;
            if (led_latch) begin
                pix_idx   <= 0;                          // next shift starts from pixel 0
                slice_idx <= slice_idx + 1;
                latch_gap <= 1;
                gap_ok    <= 1'b1;
            end
            if (hall) begin
                hall_count    <= hall_count + 1;
                slice_idx     <= 0;
                gap_ok        <= 1'b0;
                last_spacing  <= cyc - last_hall_cyc;
                last_hall_cyc <= cyc;
            end
        end
    end

    a_idle_before_lock: assert property (@(posedge clk_in) disable iff (reset)
        hall_count < 2 |-> !led_valid && !led_latch && !locked)
        else begin
            framing_errs++;
            $display("idle_before_lock: LED output or lock seen before the second hall pulse");
        end

    a_run_length: assert property (@(posedge clk_in) disable iff (reset)
        led_latch |-> pix_idx == PIXELS_PER_SLICE)
        else begin
            framing_errs++;
            $display("Fail run_length: expected %0d actual %0d", PIXELS_PER_SLICE,
                     $sampled(pix_idx));
        end

    a_run_contiguous: assert property (@(posedge clk_in) disable iff (reset)
        led_valid && pix_idx < PIXELS_PER_SLICE - 1 |=> led_valid)
        else begin
            framing_errs++;
            $display("run_contiguous: led_valid dropped in the middle of a shift");
        end

    a_no_extra_valid: assert property (@(posedge clk_in) disable iff (reset)
        led_valid |-> pix_idx < PIXELS_PER_SLICE)
        else begin
            framing_errs++;
            $display("no_extra_valid: led_valid stayed high past the last pixel of a shift");
        end

    a_pixel: assert property (@(posedge clk_in) disable iff (reset)
        led_valid |-> led_data == exp_pix)
        else begin
            pixel_errs++;
            $display("Fail pixel slice %0d pixel %0d: expected %h actual %h", $sampled(slice_idx),
                     $sampled(pix_idx), $sampled(exp_pix), $sampled(led_data));
        end

    a_latch_count: assert property (@(posedge clk_in) disable iff (reset)
        hall && hall_count >= 2 |-> slice_idx == ROTATIONAL_RES)
        else begin
            timing_errs++;
            $display("Fail latch_count: expected %0d actual %0d", ROTATIONAL_RES,
                     $sampled(slice_idx));
        end

    // inside one revolution the latches follow the period measured on the revolution before
    a_slice_len: assert property (@(posedge clk_in) disable iff (reset)
        led_latch && gap_ok |-> latch_gap == (last_spacing >> SLICE_SHIFT))
        else begin
            timing_errs++;
            $display("Fail slice_len: expected %0d actual %0d",
                     $sampled(last_spacing) >> SLICE_SHIFT, $sampled(latch_gap));
        end

    task automatic pulse_hall();
        hall <= 1'b1;
        @(posedge clk_in);
        hall <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_in);
    endtask

    task automatic wait_lock(output int used);
        used = 0;
        while (!locked && used < LOCK_TIMEOUT) begin
            @(posedge clk_in);
            used++;
        end
        if (!locked) begin
            timeout_errs++;
            $display("timeout: locked did not rise after the second hall pulse");
        end
    endtask

    task automatic wait_latches(input int count);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        while (seen < count && waited < TAIL_TIMEOUT) begin
            @(posedge clk_in);
            waited++;
            if (led_latch) seen++;
        end
        if (seen < count) begin
            timeout_errs++;
            $display("timeout: only %0d of %0d latches after the last hall pulse", seen, count);
        end
    endtask

    initial begin
        int used;
        reset <= 1'b1;
        hall  <= 1'b0;
        repeat (2) @(posedge clk_in);
        reset <= 1'b0;
        idle_cycles(50);
        // fast revolutions first, then slower ones with a little jitter
        for (int n = 0; n <= NUM_FAST + NUM_SLOW; n++) begin
            pulse_hall();
            used = 0;
            if (n == 1) wait_lock(used);
            if (n < NUM_FAST) begin
                idle_cycles(FAST_REV - 1 - used);
            end else if (n < NUM_FAST + NUM_SLOW) begin
                rng_state = xorshift(rng_state);
                idle_cycles(SLOW_REV + int'(rng_state[7:0]) - 1);
            end
        end
        wait_latches(TAIL_LATCHES);
        $display("errors: pixel %0d, framing %0d, timing %0d, timeout %0d",
                 pixel_errs, framing_errs, timing_errs, timeout_errs);
        if (pixel_errs + framing_errs + timing_errs + timeout_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/pov_pkg.sv
design/theta_tracker.sv
design/scan_sequencer.sv
design/hemi_sphere_frame.sv
design/column_serializer.sv
design/pov_display_top.sv
sim/tb_pov_display.sv

// ==== Makefile ====
# Verilator build of the POV frame path testbench, any variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= tb_pov_display
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, a missing pass line counts as a failure too
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
